// ==== list.f ====
source/modfield_pkg.sv
source/operand_ram.sv
source/write_arbiter.sv
source/mop_sequencer.sv
source/arith_pipe.sv
source/mod_inverter.sv
source/apb_bridge.sv
source/modfield_top.sv
test/tb_modfield.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the modfield simulation with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_modfield -Mdir obj_dir -f list.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_modfield 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -Fxq "Test completed successfully"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1

// ==== source/apb_bridge.sv ====
`timescale 1ns/10ps
`default_nettype none

module apb_bridge
    import modfield_pkg::*;
#(
    parameter int DATA_W = DEF_DATA_W,
    parameter int ADDR_W = DEF_ADDR_W
) (
    input  logic               clk,
    input  logic               rstn,
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  logic [PADDR_W-1:0] paddr,
    input  logic [PDATA_W-1:0] pwdata,
    output logic [PDATA_W-1:0] prdata,
    output logic               pready,
    output logic               pslverr,
    input  logic               busy,
    input  logic               done,
    input  logic [DATA_W-1:0]  rd1_data,
    output logic               start,
    output logic [FUNC_W-1:0]  func,
    output logic               host_we,
    output logic [ADDR_W-1:0]  host_addr,
    output logic [DATA_W-1:0]  host_wdata,
    output logic [ADDR_W-1:0]  host_rd_addr
);

    logic access;
    logic sel_mem;
    logic sel_ctrl;
    logic sel_status;
    logic mem_rd;
    logic ctrl_wr;
    logic rd_wait;
    logic done_sticky;

    assign access     = psel && penable;
    assign sel_mem    = paddr < PADDR_W'(MEM_SPAN);
    assign sel_ctrl   = paddr == PADDR_W'(REG_CTRL);
    assign sel_status = paddr == PADDR_W'(REG_STATUS);
    assign mem_rd     = access && sel_mem && !pwrite && !busy;
    assign ctrl_wr    = access && sel_ctrl && pwrite && !busy;

    // Memory reads wait one cycle for the registered port
    assign pready  = access && (!mem_rd || rd_wait);
    assign pslverr = access && busy && (sel_mem || (sel_ctrl && pwrite && pwdata[CTRL_START]));

    assign host_we      = access && pwrite && sel_mem && !busy;
    assign host_addr    = paddr[ADDR_W+1:2];
    assign host_rd_addr = paddr[ADDR_W+1:2];
    assign host_wdata   = pwdata[DATA_W-1:0];

    always_comb begin
        prdata = '0;
        if (sel_mem) begin
            prdata = PDATA_W'(rd1_data);
        end else if (sel_status) begin
            prdata = PDATA_W'({done_sticky, busy});
        end else if (sel_ctrl) begin
            prdata = PDATA_W'(func) << CTRL_FUNC_LSB;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            rd_wait     <= 1'b0;
            start       <= 1'b0;
            func        <= '0;
            done_sticky <= 1'b0;
        end else begin
            rd_wait <= mem_rd && !rd_wait;
            start   <= ctrl_wr && pwdata[CTRL_START];
            if (ctrl_wr) begin
                func <= pwdata[CTRL_FUNC_LSB +: FUNC_W];
            end
            if (ctrl_wr && pwdata[CTRL_START]) begin
                done_sticky <= 1'b0;
            end else if (done) begin
                done_sticky <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/arith_pipe.sv ====
`timescale 1ns/10ps
`default_nettype none

module arith_pipe
    import modfield_pkg::*;
#(
    parameter int DATA_W  = DEF_DATA_W,
    parameter int ADDR_W  = DEF_ADDR_W,
    parameter int MODULUS = DEF_MODULUS
) (
    input  logic              clk,
    input  logic              rstn,
    input  mop_u              mop,
    input  logic              mop_valid,
    input  logic [DATA_W-1:0] rd0_data,
    input  logic [DATA_W-1:0] rd1_data,
    output logic              pipe_we,
    output logic [ADDR_W-1:0] pipe_waddr,
    output logic [DATA_W-1:0] pipe_wdata
);

    localparam int                  DLY     = PIPE_LAT - 1;
    localparam int                  ST_PRE  = 0;
    localparam int                  ST_POST = PIPE_LAT - 2;
    localparam logic [DATA_W-1:0]   M       = DATA_W'(MODULUS);
    localparam logic [2*DATA_W-1:0] M_WIDE  = (2*DATA_W)'(MODULUS);

    logic [DLY-1:0]        d_vld;
    mop_u [DLY-1:0]        d_mop;
    logic [DATA_W-1:0]     pre_a;
    logic [DATA_W-1:0]     pre_b;
    logic [2*DATA_W-1:0]   prod;
    logic [2*DATA_W-1:0]   red_hi;
    logic [DATA_W-1:0]     red_lo;

    function automatic logic [DATA_W-1:0] mod_add(input logic [DATA_W-1:0] a,
                                                  input logic [DATA_W-1:0] b);
        logic [DATA_W:0] s;
        s = a + b;
        if (s >= {1'b0, M}) begin
            s = s - {1'b0, M};
        end
        return s[DATA_W-1:0];
    endfunction

    function automatic logic [DATA_W-1:0] mod_sub(input logic [DATA_W-1:0] a,
                                                  input logic [DATA_W-1:0] b);
        return (a >= b) ? a - b : a + M - b;
    endfunction

    // Conditional subtraction of M<<i for i in [lo, hi], highest first
    function automatic logic [2*DATA_W-1:0] reduce(input logic [2*DATA_W-1:0] v,
                                                   input int hi, input int lo);
        logic [2*DATA_W-1:0] r;
        r = v;
        for (int i = DATA_W - 1; i >= 0; i--) begin
            if (i <= hi && i >= lo && r >= (M_WIDE << i)) begin
                r = r - (M_WIDE << i);
            end
        end
        return r;
    endfunction

    //////////////////////////////
    // Micro-op delay line
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (!rstn) begin
            d_vld <= '0;
        end else begin
            d_vld <= {d_vld[DLY-2:0], mop_valid && mop.arith.opc == OPC_ARITH};
        end
    end

    always_ff @(posedge clk) begin
        d_mop <= {d_mop[DLY-2:0], mop};
    end

    //////////////////////////////
    // Datapath
    //////////////////////////////
    always_ff @(posedge clk) begin
        case (d_mop[ST_PRE].arith.pre)
            PRE_SUMDIFF: begin
                pre_a <= mod_add(rd0_data, rd1_data);
                pre_b <= mod_sub(rd0_data, rd1_data);
            end
            PRE_SQ: begin
                pre_a <= rd0_data;
                pre_b <= rd0_data;
            end
            default: begin
                pre_a <= rd0_data;
                pre_b <= rd1_data;
            end
        endcase
        prod   <= pre_a * pre_b;
        // Quotient bits split across the two stages
        red_hi <= reduce(prod, DATA_W - 1, DATA_W / 2);
        red_lo <= DATA_W'(reduce(red_hi, DATA_W / 2 - 1, 0));
    end

    // Post-add feeds the write port directly
    always_comb begin
        case (d_mop[ST_POST].arith.post)
            POST_DBL:  pipe_wdata = mod_add(red_lo, red_lo);
            POST_NEG:  pipe_wdata = mod_sub('0, red_lo);
            POST_NDBL: pipe_wdata = mod_sub('0, mod_add(red_lo, red_lo));
            default:   pipe_wdata = red_lo;
        endcase
    end

    assign pipe_we    = d_vld[ST_POST];
    assign pipe_waddr = ADDR_W'(d_mop[ST_POST].arith.dst);

endmodule

`default_nettype wire

// ==== source/mod_inverter.sv ====
`timescale 1ns/10ps
`default_nettype none

module mod_inverter
    import modfield_pkg::*;
#(
    parameter int DATA_W  = DEF_DATA_W,
    parameter int ADDR_W  = DEF_ADDR_W,
    parameter int MODULUS = DEF_MODULUS
) (
    input  logic              clk,
    input  logic              rstn,
    input  mop_u              mop,
    input  logic              mop_valid,
    input  logic [DATA_W-1:0] rd0_data,
    output logic              inv_we,
    output logic [ADDR_W-1:0] inv_waddr,
    output logic [DATA_W-1:0] inv_wdata
);

    localparam logic [DATA_W-1:0] M = DATA_W'(MODULUS);

    typedef enum logic [1:0] {S_IDLE, S_LOAD, S_RUN} state_e;

    state_e            state;
    logic [DATA_W-1:0] u;
    logic [DATA_W-1:0] v;
    logic [DATA_W-1:0] x1;
    logic [DATA_W-1:0] x2;

    function automatic logic [DATA_W-1:0] mod_sub(input logic [DATA_W-1:0] a,
                                                  input logic [DATA_W-1:0] b);
        return (a >= b) ? a - b : a + M - b;
    endfunction

    // x/2 mod M, M odd
    function automatic logic [DATA_W-1:0] mod_half(input logic [DATA_W-1:0] x);
        logic [DATA_W:0] s;
        s = x[0] ? {1'b0, x} + {1'b0, M} : {1'b0, x};
        return s[DATA_W:1];
    endfunction

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state  <= S_IDLE;
            inv_we <= 1'b0;
        end else begin
            inv_we <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (mop_valid && mop.inv.opc == OPC_INV) begin
                        state <= S_LOAD;
                    end
                end
                S_LOAD: begin
                    if (rd0_data == '0) begin
                        inv_we <= 1'b1;
                        state  <= S_IDLE;
                    end else begin
                        state <= S_RUN;
                    end
                end
                default: begin
                    if (u == DATA_W'(1) || v == DATA_W'(1)) begin
                        inv_we <= 1'b1;
                        state  <= S_IDLE;
                    end
                end
            endcase
        end
    end

    // Invariants x1*a = u and x2*a = v mod M
    always_ff @(posedge clk) begin
        if (state == S_IDLE && mop_valid) begin
            inv_waddr <= ADDR_W'(mop.inv.dst);
        end
        if (state == S_LOAD) begin
            u         <= rd0_data;
            v         <= M;
            x1        <= DATA_W'(1);
            x2        <= '0;
            inv_wdata <= '0;
        end else if (state == S_RUN) begin
            if (u == DATA_W'(1)) begin
                inv_wdata <= x1;
            end else if (v == DATA_W'(1)) begin
                inv_wdata <= x2;
            end else if (!u[0]) begin
                u  <= u >> 1;
                x1 <= mod_half(x1);
            end else if (!v[0]) begin
                v  <= v >> 1;
                x2 <= mod_half(x2);
            end else if (u >= v) begin
                u  <= (u - v) >> 1;
                x1 <= mod_half(mod_sub(x1, x2));
            end else begin
                v  <= (v - u) >> 1;
                x2 <= mod_half(mod_sub(x2, x1));
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/modfield_pkg.sv ====
`default_nettype none

package modfield_pkg;

    //////////////////////////////
    // Default sizes and modulus
    //////////////////////////////
    localparam int DEF_DATA_W  = 16;
    localparam int DEF_ADDR_W  = 5;
    localparam int DEF_MODULUS = 65521;

    // Issue to memory write, in cycles
    localparam int PIPE_LAT = 6;

    localparam int FUNC_W  = 3;
    localparam int PADDR_W = 9;
    localparam int PDATA_W = 32;

    // APB map
    localparam int MEM_SPAN      = 'h080;
    localparam int REG_CTRL      = 'h100;
    localparam int REG_STATUS    = 'h104;
    localparam int CTRL_START    = 0;
    localparam int CTRL_FUNC_LSB = 1;

    //////////////////////////////
    // Micro-op format
    //////////////////////////////
    localparam int MOP_W  = 24;
    localparam int MOP_AW = 5;

    typedef enum logic [1:0] {OPC_NOP, OPC_ARITH, OPC_INV, OPC_END} opc_e;
    typedef enum logic [1:0] {PRE_PASS, PRE_SUMDIFF, PRE_SQ} pre_mode_e;
    // NDBL writes -2p
    typedef enum logic [1:0] {POST_PUT, POST_DBL, POST_NEG, POST_NDBL} post_mode_e;

    typedef union packed {
        struct packed {
            opc_e                           opc;
            logic                           barrier;
            logic [MOP_AW-1:0]              dst;
            logic [MOP_AW-1:0]              src0;
            logic [MOP_AW-1:0]              src1;
            pre_mode_e                      pre;
            post_mode_e                     post;
            logic [MOP_W-3*MOP_AW-8:0]      pad;
        } arith;
        struct packed {
            opc_e                           opc;
            logic                           barrier;
            logic [MOP_AW-1:0]              dst;
            logic [MOP_AW-1:0]              src0;
            logic [MOP_W-2*MOP_AW-4:0]      unused;
        } inv;
    } mop_u;

endpackage

`default_nettype wire

// ==== source/modfield_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module modfield_top
    import modfield_pkg::*;
#(
    parameter int DATA_W  = DEF_DATA_W,
    parameter int ADDR_W  = DEF_ADDR_W,
    parameter int MODULUS = DEF_MODULUS
) (
    input  logic               clk,
    input  logic               rstn,
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  logic [PADDR_W-1:0] paddr,
    input  logic [PDATA_W-1:0] pwdata,
    output logic [PDATA_W-1:0] prdata,
    output logic               pready,
    output logic               pslverr
);

    logic              start;
    logic [FUNC_W-1:0] func;
    logic              busy;
    logic              done;
    mop_u              mop;
    logic              mop_valid;

    // Memory ports
    logic              host_we;
    logic [ADDR_W-1:0] host_addr;
    logic [DATA_W-1:0] host_wdata;
    logic [ADDR_W-1:0] host_rd_addr;
    logic [ADDR_W-1:0] rd0_addr;
    logic [ADDR_W-1:0] rd1_addr_seq;
    logic [ADDR_W-1:0] rd1_addr;
    logic [DATA_W-1:0] rd0_data;
    logic [DATA_W-1:0] rd1_data;
    logic              we;
    logic [ADDR_W-1:0] waddr;
    logic [DATA_W-1:0] wdata;
    logic              pipe_we;
    logic [ADDR_W-1:0] pipe_waddr;
    logic [DATA_W-1:0] pipe_wdata;
    logic              inv_we;
    logic [ADDR_W-1:0] inv_waddr;
    logic [DATA_W-1:0] inv_wdata;

    apb_bridge #(.DATA_W(DATA_W), .ADDR_W(ADDR_W)) u_apb (
        .clk, .rstn, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready, .pslverr,
        .busy, .done, .rd1_data, .start, .func, .host_we, .host_addr, .host_wdata,
        .host_rd_addr
    );

    mop_sequencer #(.ADDR_W(ADDR_W)) u_seq (
        .clk, .rstn, .start, .func, .inv_we, .busy, .done, .mop, .mop_valid, .rd0_addr,
        .rd1_addr_seq
    );

    write_arbiter #(.DATA_W(DATA_W), .ADDR_W(ADDR_W)) u_arb (
        .busy, .host_we, .host_addr, .host_wdata, .pipe_we, .pipe_waddr, .pipe_wdata,
        .inv_we, .inv_waddr, .inv_wdata, .host_rd_addr, .rd1_addr_seq, .we, .waddr, .wdata,
        .rd1_addr
    );

    operand_ram #(.DATA_W(DATA_W), .ADDR_W(ADDR_W)) u_ram (
        .clk, .we, .waddr, .wdata, .rd0_addr, .rd1_addr, .rd0_data, .rd1_data
    );

    arith_pipe #(.DATA_W(DATA_W), .ADDR_W(ADDR_W), .MODULUS(MODULUS)) u_pipe (
        .clk, .rstn, .mop, .mop_valid, .rd0_data, .rd1_data, .pipe_we, .pipe_waddr,
        .pipe_wdata
    );

    mod_inverter #(.DATA_W(DATA_W), .ADDR_W(ADDR_W), .MODULUS(MODULUS)) u_inv (
        .clk, .rstn, .mop, .mop_valid, .rd0_data, .inv_we, .inv_waddr, .inv_wdata
    );

endmodule

`default_nettype wire

// ==== source/mop_sequencer.sv ====
`timescale 1ns/10ps
`default_nettype none

module mop_sequencer
    import modfield_pkg::*;
#(
    parameter int ADDR_W = DEF_ADDR_W
) (
    input  logic              clk,
    input  logic              rstn,
    input  logic              start,
    input  logic [FUNC_W-1:0] func,
    input  logic              inv_we,
    output logic              busy,
    output logic              done,
    output mop_u              mop,
    output logic              mop_valid,
    output logic [ADDR_W-1:0] rd0_addr,
    output logic [ADDR_W-1:0] rd1_addr_seq
);

    localparam int PC_W  = 4;
    localparam int CNT_W = $clog2(PIPE_LAT + 1);

    logic [PC_W-1:0]     pc;
    logic [CNT_W-1:0]    inflight;
    logic [PIPE_LAT-1:0] retire_sr;
    logic                inv_pending;
    mop_u                word;
    logic                is_end;
    logic                is_arith;
    logic                is_inv;
    logic                blocked;
    logic                issue;

    function automatic mop_u mk_arith(input logic bar, input logic [MOP_AW-1:0] dst,
                                      input logic [MOP_AW-1:0] src0,
                                      input logic [MOP_AW-1:0] src1,
                                      input pre_mode_e pre, input post_mode_e post);
        mop_u w;
        w.arith.opc     = OPC_ARITH;
        w.arith.barrier = bar;
        w.arith.dst     = dst;
        w.arith.src0    = src0;
        w.arith.src1    = src1;
        w.arith.pre     = pre;
        w.arith.post    = post;
        w.arith.pad     = '0;
        return w;
    endfunction

    function automatic mop_u mk_inv(input logic [MOP_AW-1:0] dst,
                                    input logic [MOP_AW-1:0] src0);
        mop_u w;
        w             = '0;
        w.inv.opc     = OPC_INV;
        w.inv.barrier = 1'b1;
        w.inv.dst     = dst;
        w.inv.src0    = src0;
        return w;
    endfunction

    //////////////////////////////
    // Routine ROM
    //////////////////////////////
    function automatic mop_u rom_word(input logic [PC_W-1:0] addr);
        mop_u w;
        w           = '0;
        w.arith.opc = OPC_END;
        case (addr)
            // 0: r2 = r0*r1
            4'd0: w = mk_arith(1'b0, 5'd2, 5'd0, 5'd1, PRE_PASS, POST_PUT);
            // 1: r2 = (r0+r1)(r0-r1)
            4'd2: w = mk_arith(1'b0, 5'd2, 5'd0, 5'd1, PRE_SUMDIFF, POST_PUT);
            // 2: r2 = 1/r0
            4'd4: w = mk_inv(5'd2, 5'd0);
            // 3: r2 = r0/r1
            4'd6: w = mk_inv(5'd3, 5'd1);
            4'd7: w = mk_arith(1'b1, 5'd2, 5'd0, 5'd3, PRE_PASS, POST_PUT);
            // 4: r2 = -2*r0^2*r1^2
            4'd9:  w = mk_arith(1'b0, 5'd3, 5'd0, 5'd0, PRE_SQ, POST_PUT);
            4'd10: w = mk_arith(1'b0, 5'd4, 5'd1, 5'd1, PRE_SQ, POST_PUT);
            4'd11: w = mk_arith(1'b1, 5'd2, 5'd3, 5'd4, PRE_PASS, POST_NDBL);
            default: ;
        endcase
        return w;
    endfunction

    function automatic logic [PC_W-1:0] entry(input logic [FUNC_W-1:0] f);
        case (f)
            3'd0:    return 4'd0;
            3'd1:    return 4'd2;
            3'd2:    return 4'd4;
            3'd3:    return 4'd6;
            3'd4:    return 4'd9;
            default: return 4'd13;
        endcase
    endfunction

    assign word     = rom_word(pc);
    assign is_end   = word.arith.opc == OPC_END;
    assign is_arith = word.arith.opc == OPC_ARITH;
    assign is_inv   = word.inv.opc == OPC_INV;
    assign blocked  = inv_pending || (word.arith.barrier && inflight != '0);
    assign issue    = busy && !is_end && !blocked;
    // Routine over once every write has landed
    assign done     = busy && is_end && inflight == '0 && !inv_pending;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            busy        <= 1'b0;
            pc          <= '0;
            mop_valid   <= 1'b0;
            inflight    <= '0;
            retire_sr   <= '0;
            inv_pending <= 1'b0;
        end else begin
            mop_valid <= issue;
            retire_sr <= {retire_sr[PIPE_LAT-2:0], issue && is_arith};
            inflight  <= inflight + CNT_W'(issue && is_arith) - CNT_W'(retire_sr[PIPE_LAT-1]);
            if (issue && is_inv) begin
                inv_pending <= 1'b1;
            end else if (inv_we) begin
                inv_pending <= 1'b0;
            end
            if (!busy && start) begin
                busy <= 1'b1;
                pc   <= entry(func);
            end else if (done) begin
                busy <= 1'b0;
            end else if (issue) begin
                pc <= pc + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            mop          <= word;
            rd0_addr     <= ADDR_W'(word.arith.src0);
            rd1_addr_seq <= ADDR_W'(word.arith.src1);
        end
    end

endmodule

`default_nettype wire

// ==== source/operand_ram.sv ====
`timescale 1ns/10ps
`default_nettype none

module operand_ram #(
    parameter int DATA_W = 16,
    parameter int ADDR_W = 5
) (
    input  logic              clk,
    input  logic              we,
    input  logic [ADDR_W-1:0] waddr,
    input  logic [DATA_W-1:0] wdata,
    input  logic [ADDR_W-1:0] rd0_addr,
    input  logic [ADDR_W-1:0] rd1_addr,
    output logic [DATA_W-1:0] rd0_data,
    output logic [DATA_W-1:0] rd1_data
);

    logic [DATA_W-1:0] mem [2**ADDR_W];

    // Reads see the old word on a same-cycle write
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
        rd0_data <= mem[rd0_addr];
        rd1_data <= mem[rd1_addr];
    end

endmodule

`default_nettype wire

// ==== source/write_arbiter.sv ====
`timescale 1ns/10ps
`default_nettype none

module write_arbiter #(
    parameter int DATA_W = 16,
    parameter int ADDR_W = 5
) (
    input  logic              busy,
    input  logic              host_we,
    input  logic [ADDR_W-1:0] host_addr,
    input  logic [DATA_W-1:0] host_wdata,
    input  logic              pipe_we,
    input  logic [ADDR_W-1:0] pipe_waddr,
    input  logic [DATA_W-1:0] pipe_wdata,
    input  logic              inv_we,
    input  logic [ADDR_W-1:0] inv_waddr,
    input  logic [DATA_W-1:0] inv_wdata,
    input  logic [ADDR_W-1:0] host_rd_addr,
    input  logic [ADDR_W-1:0] rd1_addr_seq,
    output logic              we,
    output logic [ADDR_W-1:0] waddr,
    output logic [DATA_W-1:0] wdata,
    output logic [ADDR_W-1:0] rd1_addr
);

    // Inverter first, then pipeline, host only while idle
    always_comb begin
        if (inv_we) begin
            we    = 1'b1;
            waddr = inv_waddr;
            wdata = inv_wdata;
        end else if (pipe_we) begin
            we    = 1'b1;
            waddr = pipe_waddr;
            wdata = pipe_wdata;
        end else begin
            we    = host_we && !busy;
            waddr = host_addr;
            wdata = host_wdata;
        end
    end

    assign rd1_addr = busy ? rd1_addr_seq : host_rd_addr;

endmodule

`default_nettype wire

// ==== test/tb_modfield.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_modfield
    import modfield_pkg::*;
;

    localparam int DATA_W      = 16;
    localparam int ADDR_W      = 5;
    localparam int MODULUS     = 65521;
    localparam int CLK_PERIOD  = 40;
    localparam int NUM_RANDOM  = 20;
    // Memory test counts as three, then the routine runs of each group
    localparam int NUM_TESTS   = 3 + 4 + 7 + 2 + 1 + NUM_RANDOM;
    localparam int TEST_CYCLES = 2 * DATA_W + 4 + 4 * PIPE_LAT + 20;

    logic               clk;
    logic               rstn;
    logic               psel;
    logic               penable;
    logic               pwrite;
    logic [PADDR_W-1:0] paddr;
    logic [PDATA_W-1:0] pwdata;
    logic [PDATA_W-1:0] prdata;
    logic               pready;
    logic               pslverr;

    logic [31:0] lcg_state;
    logic [31:0] fill [2**ADDR_W];
    string       test_name;

    modfield_top #(.DATA_W(DATA_W), .ADDR_W(ADDR_W), .MODULUS(MODULUS)) DUT (
        .clk, .rstn, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready, .pslverr
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(CLK_PERIOD * (NUM_TESTS * TEST_CYCLES + 2));
        $display("Timeout after %0d cycles, the tests did not finish", NUM_TESTS * TEST_CYCLES);
        $display("Test failed");
        $fatal(1);
    end

    //////////////////////////////
    // Bus protocol checks
    //////////////////////////////
    assert property (@(posedge clk) disable iff (!rstn)
                     (psel && penable) || (!pready && !pslverr))
    else begin
        $display("pready or pslverr went high outside an APB access phase");
        $display("Test failed");
        $fatal(1);
    end

    assert property (@(posedge clk) disable iff (!rstn) !pslverr || pready)
    else begin
        $display("pslverr was raised without pready");
        $display("Test failed");
        $fatal(1);
    end

    //////////////////////////////
    // Reference model
    //////////////////////////////
    function automatic logic [31:0] mod_mul(input logic [31:0] a, input logic [31:0] b);
        logic [63:0] p;
        p = 64'(a) * 64'(b);
        return 32'(p % 64'(MODULUS));
    endfunction

    // Fermat inverse, zero maps to zero
    function automatic logic [31:0] mod_inv(input logic [31:0] a);
        logic [31:0] r;
        logic [31:0] base;
        int          e;
        r    = 32'd1;
        base = a;
        e    = MODULUS - 2;
        while (e > 0) begin
            if ((e & 1) != 0) begin
                r = mod_mul(r, base);
            end
            base = mod_mul(base, base);
            e    = e >> 1;
        end
        return r;
    endfunction

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic logic [31:0] rand_operand();
        return (lcg_next() >> 8) % MODULUS;
    endfunction

    //////////////////////////////
    // Bus tasks
    //////////////////////////////
    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected)
        else begin
            $display("error %s %s: expected %0h, actual %0h", test_name, what, expected,
                     actual);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic bus_transfer(input logic wr, input logic [PADDR_W-1:0] addr,
                                input logic [31:0] wdata, output logic [31:0] rdata,
                                output logic err);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        // Sample away from the driving edge
        @(negedge clk);
        while (!pready) begin
            @(negedge clk);
        end
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic write_mem(input int idx, input logic [31:0] val);
        logic [31:0] rd;
        logic        err;
        bus_transfer(1'b1, PADDR_W'(idx * 4), val, rd, err);
        check_value($sformatf("write r%0d pslverr", idx), 32'h0, {31'b0, err});
    endtask

    task automatic expect_mem(input int idx, input logic [31:0] expected);
        logic [31:0] rd;
        logic        err;
        bus_transfer(1'b0, PADDR_W'(idx * 4), 32'h0, rd, err);
        check_value($sformatf("read r%0d pslverr", idx), 32'h0, {31'b0, err});
        check_value($sformatf("r%0d", idx), expected, rd);
    endtask

    task automatic start_routine(input int func);
        logic [31:0] rd;
        logic        err;
        bus_transfer(1'b1, PADDR_W'(REG_CTRL), (32'(func) << CTRL_FUNC_LSB) | 32'h1, rd, err);
        check_value("start pslverr", 32'h0, {31'b0, err});
    endtask

    // Poll STATUS until busy drops, then done must be set
    task automatic wait_idle();
        logic [31:0] st;
        logic        err;
        int          polls;
        polls = 0;
        st    = 32'h1;
        while (st[0]) begin
            if (polls == TEST_CYCLES) begin
                $display("Routine still busy after %0d status polls", TEST_CYCLES);
                $display("Test failed");
                $fatal(1);
            end
            polls++;
            bus_transfer(1'b0, PADDR_W'(REG_STATUS), 32'h0, st, err);
            check_value("status pslverr", 32'h0, {31'b0, err});
        end
        check_value("status after run", 32'h2, st);
    endtask

    task automatic check_results(input int func, input logic [31:0] a, input logic [31:0] b);
        logic [31:0] e2;
        logic [31:0] e3;
        logic [31:0] e4;
        logic [31:0] t;
        e3 = '0;
        e4 = '0;
        case (func)
            0: e2 = mod_mul(a, b);
            1: e2 = mod_mul((a + b) % MODULUS, (a + MODULUS - b) % MODULUS);
            2: e2 = mod_inv(a);
            3: begin
                e3 = mod_inv(b);
                e2 = mod_mul(a, e3);
            end
            default: begin
                e3 = mod_mul(a, a);
                e4 = mod_mul(b, b);
                t  = mod_mul(mod_mul(e3, e4), 32'd2);
                e2 = (MODULUS - t) % MODULUS;
            end
        endcase
        expect_mem(0, a);
        expect_mem(1, b);
        expect_mem(2, e2);
        if (func >= 3) begin
            expect_mem(3, e3);
        end
        if (func == 4) begin
            expect_mem(4, e4);
        end
    endtask

    task automatic run_routine(input int func, input logic [31:0] a, input logic [31:0] b);
        write_mem(0, a);
        write_mem(1, b);
        start_routine(func);
        wait_idle();
        check_results(func, a, b);
    endtask

    //////////////////////////////
    // Test sequence
    //////////////////////////////
    initial begin
        logic [31:0] st;
        logic [31:0] rd;
        logic        err;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] v5;
        int          func;
        rstn      = 1'b0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        lcg_state = 32'd72634;
        test_name = "reset";
        repeat (2) @(posedge clk);
        rstn <= 1'b1;

        bus_transfer(1'b0, PADDR_W'(REG_STATUS), 32'h0, st, err);
        check_value("status", 32'h0, st);

        test_name = "memory";
        for (int i = 0; i < 2**ADDR_W; i++) begin
            fill[i] = lcg_next();
            write_mem(i, fill[i]);
        end
        // Only the low DATA_W bits are stored
        for (int i = 0; i < 2**ADDR_W; i++) begin
            expect_mem(i, {16'h0, fill[i][DATA_W-1:0]});
        end

        test_name = "multiply";
        for (int i = 0; i < 2; i++) begin
            run_routine(0, rand_operand(), rand_operand());
            run_routine(1, rand_operand(), rand_operand());
        end

        test_name = "inverse";
        run_routine(2, rand_operand(), rand_operand());
        run_routine(2, 32'd1, rand_operand());
        run_routine(2, MODULUS - 1, rand_operand());
        run_routine(2, 32'd0, rand_operand());
        test_name = "quotient";
        run_routine(3, rand_operand(), rand_operand());
        run_routine(3, rand_operand(), 32'd1);
        run_routine(3, rand_operand(), MODULUS - 1);

        test_name = "squares";
        run_routine(4, rand_operand(), rand_operand());
        run_routine(4, rand_operand(), rand_operand());

        // Refused accesses during a quotient run
        test_name = "busy";
        a  = rand_operand();
        b  = rand_operand();
        v5 = rand_operand();
        write_mem(5, v5);
        write_mem(0, a);
        write_mem(1, b);
        start_routine(3);
        bus_transfer(1'b1, PADDR_W'(5 * 4), ~v5, rd, err);
        check_value("write while busy pslverr", 32'h1, {31'b0, err});
        bus_transfer(1'b1, PADDR_W'(REG_CTRL), 32'h1, rd, err);
        check_value("start while busy pslverr", 32'h1, {31'b0, err});
        bus_transfer(1'b0, PADDR_W'(0), 32'h0, rd, err);
        check_value("read while busy pslverr", 32'h1, {31'b0, err});
        wait_idle();
        check_results(3, a, b);
        expect_mem(5, v5);

        test_name = "random";
        for (int i = 0; i < NUM_RANDOM; i++) begin
            func = int'((lcg_next() >> 8) % 5);
            run_routine(func, rand_operand(), rand_operand());
        end

        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire
